//--- Makefile
# Verilator build for the serial debug monitor testbench

VERILATOR  ?= verilator
TOP        := tb_uart_monitor
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
PASS_TEXT  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/mem_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word memory request bus, req/ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface mem_bus_if import mon_pkg::*; ();

	logic req;
	logic we;
	mem_addr_t addr;
	word_t wdata;
	logic ack;
	word_t rdata;

	// request stays stable until the ack pulse
	modport requester (output req, output we, output addr, output wdata,
		input ack, input rdata);

	modport arbiter (input req, input we, input addr, input wdata,
		output ack, output rdata);

endinterface

//--- common/mon_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug monitor definitions: memory
// geometry and command/reply byte codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mon_pkg;

	// shared memory is 256 words of 32 bits
	localparam int mem_depth = 256;

	typedef logic [31:0] word_t;
	typedef logic [7:0] mem_addr_t;

	// command opcodes
	localparam logic [7:0] cmd_write = 8'h57;
	localparam logic [7:0] cmd_read = 8'h52;

	// reply codes
	localparam logic [7:0] rsp_ok = 8'h4b;
	localparam logic [7:0] rsp_bad = 8'h3f;

endpackage

//--- common/uart_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART constants shared by the serial
// front end: baud timing and FIFO sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package uart_pkg;

	// 100 MHz clock, 921600 bps
	localparam int bit_period = 109;

	// start edge to middle of start bit
	localparam int half_period = 54;

	// width of the baud counters
	localparam int baud_cnt_w = $clog2(bit_period + 1);

	// rx and tx FIFO geometry
	localparam int fifo_depth = 8;
	localparam int fifo_ptr_w = 3;

	typedef logic [7:0] byte_t;

endpackage

//--- filelist.f
+incdir+verification
common/uart_pkg.sv
common/mon_pkg.sv
common/mem_bus_if.sv
source/ram_1r1w.sv
uart/uart_if.sv
monitor/monitor_cmd.sv
source/mem_arbiter.sv
source/uart_monitor_top.sv
verification/tb_uart_monitor.sv

//--- monitor/monitor_cmd.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command interpreter: byte frames in,
// memory word access, reply bytes out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module monitor_cmd import uart_pkg::*, mon_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	output logic      rx_rden,
	input  byte_t     rx_rdata,
	input  logic      rx_dvalid,
	output byte_t     tx_wdata,
	output logic      tx_wten,
	input  logic      tx_full,
	mem_bus_if.requester mem
);

	typedef enum logic [2:0] {st_op, st_addr, st_data, st_mem, st_reply} state_t;

	state_t state;
	logic is_write;
	logic [1:0] byte_idx;
	logic [2:0] reply_left;
	mem_addr_t addr_q;
	word_t wdata_q;
	word_t reply_q;

	// command bytes are only taken outside the access and reply phases
	assign rx_rden = rx_dvalid && (state == st_op || state == st_addr || state == st_data);

	assign tx_wten = (state == st_reply) && !tx_full;
	assign tx_wdata = reply_q[31:24];

	assign mem.req = (state == st_mem);
	assign mem.we = is_write;
	assign mem.addr = addr_q;
	assign mem.wdata = wdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_op;
			is_write <= 1'b0;
			byte_idx <= '0;
			reply_left <= '0;
		end else begin
			case (state)
				st_op: begin
					if (rx_dvalid && (rx_rdata == cmd_write || rx_rdata == cmd_read)) begin
						is_write <= (rx_rdata == cmd_write);
						state <= st_addr;
					end else if (rx_dvalid) begin
						// unknown opcode gets a single error byte
						reply_left <= 3'd1;
						state <= st_reply;
					end
				end
				st_addr: begin
					if (rx_dvalid) begin
						byte_idx <= '0;
						state <= is_write ? st_data : st_mem;
					end
				end
				st_data: begin
					if (rx_dvalid) begin
						byte_idx <= byte_idx + 2'd1;
						if (byte_idx == 2'd3)
							state <= st_mem;
					end
				end
				st_mem: begin
					if (mem.ack) begin
						reply_left <= is_write ? 3'd1 : 3'd4;
						state <= st_reply;
					end
				end
				st_reply: begin
					if (!tx_full) begin
						reply_left <= reply_left - 3'd1;
						if (reply_left == 3'd1)
							state <= st_op;
					end
				end
				default: state <= st_op;
			endcase
		end
	end

	// address, write word and reply shifter
	always_ff @(posedge clk) begin
		case (state)
			st_op: begin
				if (rx_dvalid)
					reply_q <= {rsp_bad, 24'h0};
			end
			st_addr: begin
				if (rx_dvalid)
					addr_q <= rx_rdata;
			end
			st_data: begin
				// msb arrives first
				if (rx_dvalid)
					wdata_q <= {wdata_q[23:0], rx_rdata};
			end
			st_mem: begin
				if (mem.ack)
					reply_q <= is_write ? {rsp_ok, 24'h0} : mem.rdata;
			end
			st_reply: begin
				if (!tx_full)
					reply_q <= {reply_q[23:0], 8'h00};
			end
			default: ;
		endcase
	end

endmodule

//--- source/mem_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter, monitor and host
// sharing one word memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_arbiter import mon_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	mem_bus_if.arbiter mon,
	mem_bus_if.arbiter host,
	output logic      ram_wen,
	output mem_addr_t ram_addr,
	output word_t     ram_wdata,
	input  word_t     ram_rdata
);

	logic acc_valid;
	logic acc_host;
	logic prio_host;
	logic ack_mon_q;
	logic ack_host_q;
	logic mon_elig;
	logic host_elig;
	logic grant_host;
	logic grant_mon;
	word_t rdata_q;

	// a side in its ack cycle still shows req, skip it
	assign mon_elig = mon.req && !ack_mon_q;
	assign host_elig = host.req && !ack_host_q;
	assign grant_host = !acc_valid && host_elig && (!mon_elig || prio_host);
	assign grant_mon = !acc_valid && mon_elig && !grant_host;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_valid <= 1'b0;
			acc_host <= 1'b0;
			prio_host <= 1'b1;
			ack_mon_q <= 1'b0;
			ack_host_q <= 1'b0;
		end else begin
			acc_valid <= grant_host || grant_mon;
			if (grant_host || grant_mon) begin
				acc_host <= grant_host;
				prio_host <= grant_mon;
			end
			ack_host_q <= acc_valid && acc_host;
			ack_mon_q <= acc_valid && !acc_host;
		end
	end

	// access happens in the cycle after the grant
	assign ram_wen = acc_valid && (acc_host ? host.we : mon.we);
	assign ram_addr = acc_host ? host.addr : mon.addr;
	assign ram_wdata = acc_host ? host.wdata : mon.wdata;

	always_ff @(posedge clk) begin
		if (acc_valid)
			rdata_q <= ram_rdata;
	end

	assign mon.ack = ack_mon_q;
	assign mon.rdata = rdata_q;
	assign host.ack = ack_host_q;
	assign host.rdata = rdata_q;

endmodule

//--- source/ram_1r1w.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Storage array, one sync write port
// and one combinational read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ram_1r1w #(
	parameter type data_t = logic [7:0],
	parameter int depth = 8
) (
	input  logic                     clk,
	input  logic                     wen,
	input  logic [$clog2(depth)-1:0] waddr,
	input  data_t                    wdata,
	input  logic [$clog2(depth)-1:0] raddr,
	output data_t                    rdata
);

	data_t mem [depth];

	always_ff @(posedge clk) begin
		if (wen)
			mem[waddr] <= wdata;
	end

	assign rdata = mem[raddr];

endmodule

//--- source/uart_monitor_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial debug monitor top: UART, command
// interpreter, arbiter and shared memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module uart_monitor_top import uart_pkg::*, mon_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      rx,
	output logic      tx,
	input  logic      host_req,
	input  logic      host_we,
	input  mem_addr_t host_addr,
	input  word_t     host_wdata,
	output word_t     host_rdata,
	output logic      host_ack
);

	byte_t rx_rdata;
	logic rx_rden;
	logic rx_dvalid;
	byte_t tx_wdata;
	logic tx_wten;
	logic tx_full;
	logic ram_wen;
	mem_addr_t ram_addr;
	word_t ram_wdata;
	word_t ram_rdata;

	mem_bus_if mon_bus ();
	mem_bus_if host_bus ();

	// host side arrives on plain ports
	assign host_bus.req = host_req;
	assign host_bus.we = host_we;
	assign host_bus.addr = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_rdata = host_bus.rdata;
	assign host_ack = host_bus.ack;

	uart_if i_uart (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.tx        (tx),
		.rx_rden   (rx_rden),
		.rx_rdata  (rx_rdata),
		.rx_dvalid (rx_dvalid),
		.tx_wdata  (tx_wdata),
		.tx_wten   (tx_wten),
		.tx_full   (tx_full)
	);

	monitor_cmd i_monitor (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx_rden   (rx_rden),
		.rx_rdata  (rx_rdata),
		.rx_dvalid (rx_dvalid),
		.tx_wdata  (tx_wdata),
		.tx_wten   (tx_wten),
		.tx_full   (tx_full),
		.mem       (mon_bus.requester)
	);

	mem_arbiter i_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.mon       (mon_bus.arbiter),
		.host      (host_bus.arbiter),
		.ram_wen   (ram_wen),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	ram_1r1w #(.data_t(word_t), .depth(mem_depth)) i_mem (
		.clk   (clk),
		.wen   (ram_wen),
		.waddr (ram_addr),
		.wdata (ram_wdata),
		.raddr (ram_addr),
		.rdata (ram_rdata)
	);

endmodule

//--- uart/uart_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART with oversampled receiver and
// counter-driven transmitter, 8-deep FIFOs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module uart_if import uart_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  rx,
	output logic  tx,
	input  logic  rx_rden,
	output byte_t rx_rdata,
	output logic  rx_dvalid,
	input  byte_t tx_wdata,
	input  logic  tx_wten,
	output logic  tx_full
);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;
	typedef enum logic [1:0] {tx_idle, tx_shift, tx_wait} tx_state_t;

	logic rx_meta;
	logic rx_sync;
	logic [4:0] rx_hist;
	logic [2:0] rx_ones;
	logic rx_major;
	logic rx_fall;
	rx_state_t rx_state;
	logic [baud_cnt_w-1:0] rx_cnt;
	logic rx_tick;
	logic [2:0] rx_bit;
	byte_t rx_shift;
	logic rx_push;
	logic [fifo_ptr_w-1:0] rx_wptr;
	logic [fifo_ptr_w-1:0] rx_rptr;
	logic [fifo_ptr_w:0] rx_count;

	tx_state_t tx_state;
	logic [9:0] tx_sr;
	logic [3:0] tx_left;
	logic [baud_cnt_w-1:0] tx_cnt;
	logic tx_tick;
	logic tx_start;
	logic tx_pop;
	byte_t tx_head;
	logic [fifo_ptr_w-1:0] tx_wptr;
	logic [fifo_ptr_w-1:0] tx_rptr;
	logic [fifo_ptr_w:0] tx_count;

	// two sync flops then a five-sample history
	// all of them reset to the idle high level
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_hist <= '1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_hist <= {rx_hist[3:0], rx_sync};
		end
	end

	assign rx_ones = {2'd0, rx_hist[0]} + {2'd0, rx_hist[1]} + {2'd0, rx_hist[2]}
		+ {2'd0, rx_hist[3]} + {2'd0, rx_hist[4]};
	assign rx_major = (rx_ones >= 3'd3);
	assign rx_fall = ~rx_sync & rx_hist[0];
	assign rx_tick = (rx_cnt == baud_cnt_w'(1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_state <= rx_idle;
			rx_cnt <= '0;
			rx_bit <= '0;
		end else begin
			if (rx_cnt != '0)
				rx_cnt <= rx_cnt - 1'b1;
			case (rx_state)
				rx_idle: begin
					if (rx_fall) begin
						rx_cnt <= baud_cnt_w'(half_period);
						rx_state <= rx_start;
					end
				end
				rx_start: begin
					// high at mid start bit means a glitch
					if (rx_tick && rx_major) begin
						rx_state <= rx_idle;
					end else if (rx_tick) begin
						rx_cnt <= baud_cnt_w'(bit_period);
						rx_bit <= '0;
						rx_state <= rx_data;
					end
				end
				rx_data: begin
					if (rx_tick) begin
						rx_cnt <= baud_cnt_w'(bit_period);
						rx_bit <= rx_bit + 3'd1;
						if (rx_bit == 3'd7)
							rx_state <= rx_stop;
					end
				end
				default: begin
					if (rx_tick)
						rx_state <= rx_idle;
				end
			endcase
		end
	end

	// lsb arrives first and enters at the top
	always_ff @(posedge clk) begin
		if (rx_state == rx_data && rx_tick)
			rx_shift <= {rx_major, rx_shift[7:1]};
	end

	// bad stop bit drops the frame
	assign rx_push = (rx_state == rx_stop) && rx_tick && rx_major;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_wptr <= '0;
			rx_rptr <= '0;
			rx_count <= '0;
		end else begin
			if (rx_push)
				rx_wptr <= rx_wptr + 1'b1;
			if (rx_rden)
				rx_rptr <= rx_rptr + 1'b1;
			if (rx_push && !rx_rden)
				rx_count <= rx_count + 1'b1;
			else if (rx_rden && !rx_push)
				rx_count <= rx_count - 1'b1;
		end
	end

	assign rx_dvalid = (rx_count != '0);

	ram_1r1w #(.data_t(byte_t), .depth(fifo_depth)) i_rx_fifo (
		.clk   (clk),
		.wen   (rx_push),
		.waddr (rx_wptr),
		.wdata (rx_shift),
		.raddr (rx_rptr),
		.rdata (rx_rdata)
	);

	// transmit FIFO
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_wptr <= '0;
			tx_rptr <= '0;
			tx_count <= '0;
		end else begin
			if (tx_wten)
				tx_wptr <= tx_wptr + 1'b1;
			if (tx_pop)
				tx_rptr <= tx_rptr + 1'b1;
			if (tx_wten && !tx_pop)
				tx_count <= tx_count + 1'b1;
			else if (tx_pop && !tx_wten)
				tx_count <= tx_count - 1'b1;
		end
	end

	assign tx_full = (tx_count == (fifo_ptr_w + 1)'(fifo_depth));

	ram_1r1w #(.data_t(byte_t), .depth(fifo_depth)) i_tx_fifo (
		.clk   (clk),
		.wen   (tx_wten),
		.waddr (tx_wptr),
		.wdata (tx_wdata),
		.raddr (tx_rptr),
		.rdata (tx_head)
	);

	assign tx_tick = (tx_cnt == baud_cnt_w'(1));
	assign tx_start = (tx_state == tx_idle) && (tx_count != '0);
	// pop once the stop bit has been on the line for a full period
	assign tx_pop = (tx_state == tx_shift) && tx_tick && (tx_left == 4'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_state <= tx_idle;
			tx_sr <= '1;
			tx_left <= '0;
			tx_cnt <= '0;
		end else begin
			if (tx_cnt != '0)
				tx_cnt <= tx_cnt - 1'b1;
			case (tx_state)
				tx_idle: begin
					if (tx_start) begin
						tx_sr <= {1'b1, tx_head, 1'b0};
						tx_left <= 4'd9;
						tx_cnt <= baud_cnt_w'(bit_period);
						tx_state <= tx_shift;
					end
				end
				tx_shift: begin
					if (tx_pop) begin
						tx_state <= tx_wait;
					end else if (tx_tick) begin
						tx_sr <= {1'b1, tx_sr[9:1]};
						tx_left <= tx_left - 4'd1;
						tx_cnt <= baud_cnt_w'(bit_period);
					end
				end
				default: tx_state <= tx_idle;
			endcase
		end
	end

	// stop bit stays in bit 0 through wait and idle
	assign tx = tx_sr[0];

endmodule

//--- verification/tb_uart_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial line and host bus driver tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// one 8N1 frame on rx, each bit held for bit_period clocks
task automatic send_byte(input byte_t value);
	@(posedge clk);
	rx <= 1'b0;
	for (int i = 0; i < 8; i++) begin
		repeat (bit_period) @(posedge clk);
		rx <= value[i];
	end
	repeat (bit_period) @(posedge clk);
	rx <= 1'b1;
	repeat (bit_period) @(posedge clk);
endtask

// find the start edge, then sample each bit near its middle
task automatic receive_byte(output byte_t value);
	byte_t data;
	data = '0;
	@(negedge clk);
	while (tx !== 1'b0)
		@(negedge clk);
	repeat (half_period) @(negedge clk);
	assert (tx === 1'b0) else abort_run("start bit on tx did not last to its middle");
	for (int i = 0; i < 8; i++) begin
		repeat (bit_period) @(negedge clk);
		data[i] = tx;
	end
	repeat (bit_period) @(negedge clk);
	assert (tx === 1'b1) else abort_run("stop bit on tx was not high");
	value = data;
endtask

// req held until the ack pulse, dropped in the cycle after it
task automatic host_access(input logic we, input mem_addr_t addr, input word_t wdata,
	output word_t rdata);
	int waited;
	waited = 0;
	@(posedge clk);
	host_req <= 1'b1;
	host_we <= we;
	host_addr <= addr;
	host_wdata <= wdata;
	@(negedge clk);
	while (host_ack !== 1'b1 && waited < ack_limit) begin
		@(negedge clk);
		waited++;
	end
	assert (host_ack === 1'b1) else abort_run("host_ack did not arrive within the wait limit");
	rdata = host_rdata;
	@(posedge clk);
	host_req <= 1'b0;
endtask

`endif

//--- verification/tb_uart_monitor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the serial debug monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_uart_monitor import uart_pkg::*, mon_pkg::*; ();

	// the tests take about 56 frames in all
	// limit is three times a rounded-up 60
	localparam int frame_cycles = 10 * bit_period;
	localparam int test_frames = 60;
	localparam int timeout_cycles = 3 * test_frames * frame_cycles;
	localparam int ack_limit = 16;
	localparam int glitch_len = half_period / 3;

	logic clk;
	logic rst_n;
	logic rx;
	logic tx;
	logic host_req;
	logic host_we;
	mem_addr_t host_addr;
	word_t host_wdata;
	word_t host_rdata;
	logic host_ack;

	int cycle_count = 0;
	logic rsp_window = 1'b0;
	string test_name = "reset";
	byte_t cmd_buf [6];
	byte_t rsp_buf [4];
	word_t ref_mem [mem_depth];
	logic ref_valid [mem_depth];

	uart_monitor_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx         (rx),
		.tx         (tx),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.host_ack   (host_ack)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_equal(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else
			abort_run($sformatf("Error: test %s, %s: expected %08h actual %08h",
				test_name, what, expected, actual));
	endtask

	`include "tb_uart_tasks.svh"

	// command bytes out and reply bytes in run side by side
	task automatic run_command(input int n_cmd, input int n_rsp);
		rsp_window = 1'b1;
		fork
			begin
				for (int i = 0; i < n_cmd; i++)
					send_byte(cmd_buf[i]);
			end
			begin
				for (int j = 0; j < n_rsp; j++)
					receive_byte(rsp_buf[j]);
			end
		join
		rsp_window = 1'b0;
	endtask

	task automatic uart_write(input mem_addr_t addr, input word_t data);
		cmd_buf[0] = cmd_write;
		cmd_buf[1] = addr;
		cmd_buf[2] = data[31:24];
		cmd_buf[3] = data[23:16];
		cmd_buf[4] = data[15:8];
		cmd_buf[5] = data[7:0];
		run_command(6, 1);
		check_equal("write reply", 32'(rsp_ok), 32'(rsp_buf[0]));
		ref_mem[addr] = data;
		ref_valid[addr] = 1'b1;
	endtask

	task automatic uart_check_read(input mem_addr_t addr);
		cmd_buf[0] = cmd_read;
		cmd_buf[1] = addr;
		run_command(2, 4);
		check_equal("uart read data", ref_mem[addr],
			{rsp_buf[0], rsp_buf[1], rsp_buf[2], rsp_buf[3]});
	endtask

	task automatic host_write(input mem_addr_t addr, input word_t data);
		word_t unused;
		host_access(1'b1, addr, data, unused);
		ref_mem[addr] = data;
		ref_valid[addr] = 1'b1;
	endtask

	task automatic host_check_read(input mem_addr_t addr);
		word_t got;
		host_access(1'b0, addr, '0, got);
		if (ref_valid[addr])
			check_equal("host read data", ref_mem[addr], got);
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			abort_run("timeout: the run went past its cycle limit");
	end

	// tx must idle high whenever no reply is expected
	always @(negedge clk) begin
		if (cycle_count > 0 && !rsp_window)
			assert (tx === 1'b1) else abort_run("tx left idle while no reply was expected");
	end

	initial begin
		mem_addr_t addr_a;
		mem_addr_t addr_b;
		mem_addr_t addr_c;
		mem_addr_t addr_h;
		byte_t op;
		logic uart_busy;
		int host_ops;
		void'($urandom(32'h77d60b5b));
		for (int k = 0; k < mem_depth; k++)
			ref_valid[k] = 1'b0;
		rst_n = 1'b0;
		rx = 1'b1;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_equal("tx after reset", 32'd1, 32'(tx));

		test_name = "uart_write_read";
		addr_a = mem_addr_t'($urandom);
		uart_write(addr_a, $urandom);
		uart_check_read(addr_a);

		test_name = "host_to_uart";
		addr_b = mem_addr_t'($urandom);
		host_write(addr_b, $urandom);
		uart_check_read(addr_b);

		test_name = "uart_to_host";
		addr_c = mem_addr_t'($urandom);
		uart_write(addr_c, $urandom);
		host_check_read(addr_c);

		test_name = "bad_opcode";
		do
			op = byte_t'($urandom);
		while (op == cmd_write || op == cmd_read);
		cmd_buf[0] = op;
		run_command(1, 1);
		check_equal("unknown opcode reply", 32'(rsp_bad), 32'(rsp_buf[0]));
		uart_check_read(addr_a);

		// short low pulse that the receiver drops at mid start bit
		test_name = "rx_glitch";
		@(posedge clk);
		rx <= 1'b0;
		repeat (glitch_len) @(posedge clk);
		rx <= 1'b1;
		repeat (2 * bit_period) @(posedge clk);
		uart_check_read(addr_b);

		test_name = "host_during_uart";
		addr_c = mem_addr_t'($urandom);
		uart_busy = 1'b1;
		host_ops = 0;
		fork
			begin
				uart_write(addr_c, $urandom);
				uart_busy = 1'b0;
			end
			begin
				while (uart_busy) begin
					addr_h = mem_addr_t'($urandom);
					if (addr_h == addr_c)
						addr_h = addr_h + 8'd1;
					if (ref_valid[addr_h] && $urandom_range(1, 0) == 1)
						host_check_read(addr_h);
					else
						host_write(addr_h, $urandom);
					host_ops++;
				end
			end
		join
		assert (host_ops > 100) else abort_run("too few host accesses overlapped the UART write");
		host_check_read(addr_c);
		uart_check_read(addr_h);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
